// ==== hw/csrIsaPkg.sv ====
package csrIsaPkg;

    // micro-opcodes handled by the CSR unit
    typedef enum logic [7:0] {
        csrRd     = 8'h01,
        csrWr     = 8'h02,
        csrXchg   = 8'h03,
        opSyscall = 8'h10,
        opBreak   = 8'h11,
        opErtn    = 8'h12,
        opIdle    = 8'h13
    } csrOpE;

    localparam int csrNumW = 14;

    localparam logic [csrNumW-1:0] csrCrmd   = 14'h000;
    localparam logic [csrNumW-1:0] csrPrmd   = 14'h001;
    localparam logic [csrNumW-1:0] csrEstat  = 14'h005;
    localparam logic [csrNumW-1:0] csrEra    = 14'h006;
    localparam logic [csrNumW-1:0] csrEentry = 14'h00c;
    localparam logic [csrNumW-1:0] csrSave0  = 14'h030;

    // ESTAT ecode values
    typedef enum logic [6:0] {
        excPpi = 7'h07,
        excSys = 7'h0b,
        excBrk = 7'h0c
    } excCodeE;

    typedef enum logic [1:0] {
        plv0 = 2'd0,
        plv3 = 2'd3
    } plvE;

    // plv in [1:0], ie in [2] for both CRMD and PRMD
    localparam int plvIeW   = 3;
    localparam int ecodeLsb = 16;
    localparam int ecodeW   = 6;

    // software-writable bits
    localparam logic [31:0] crmdWrMask   = 32'h0000_0007;
    localparam logic [31:0] prmdWrMask   = 32'h0000_0007;
    localparam logic [31:0] estatWrMask  = 32'h0000_0003;
    localparam logic [31:0] eraWrMask    = 32'hffff_ffff;
    localparam logic [31:0] eentryWrMask = 32'hffff_ffc0;
    localparam logic [31:0] saveWrMask   = 32'hffff_ffff;

    localparam logic [31:0] eentryReset  = 32'h1c00_0000;

endpackage

// ==== hw/csrUnitPkg.sv ====
package csrUnitPkg;

    localparam int dataW   = 32;
    localparam int robPtrW = 6;
    localparam int pregW   = 7;

    // from the reservation station
    typedef struct packed {
        csrIsaPkg::csrOpE              op;
        logic [csrIsaPkg::csrNumW-1:0] csrNum;
        logic [robPtrW-1:0]            robPtr;
        logic [pregW-1:0]              pdest;
        logic [dataW-1:0]              pc;
        // write value for csrwr and csrxchg
        logic [dataW-1:0]              rdData;
        // xchg mask
        logic [dataW-1:0]              rjData;
    } csrIssueT;

    typedef struct packed {
        logic                valid;
        logic [robPtrW-1:0]  robPtr;
        logic                redirect;
        logic                isException;
        csrIsaPkg::excCodeE  code;
        logic [dataW-1:0]    target;
        logic                idle;
    } robReportT;

    typedef struct packed {
        logic             valid;
        logic [pregW-1:0] addr;
        logic [dataW-1:0] data;
    } wbT;

    // one retiring CSR effect, seen by the register file
    typedef struct packed {
        logic                          re;
        logic                          we;
        logic [csrIsaPkg::csrNumW-1:0] num;
        logic [dataW-1:0]              wdata;
        logic [dataW-1:0]              wmask;
        logic                          excEnter;
        logic                          ertn;
        csrIsaPkg::excCodeE            excCode;
        logic [dataW-1:0]              excPc;
    } csrAccessT;

endpackage

// ==== hw/csrRegFile.sv ====
module csrRegFile #(
    parameter int numSave = 4
) (
    input  logic                         Clk,
    input  logic                         reset,
    input  csrUnitPkg::csrAccessT        access,
    output logic [csrUnitPkg::dataW-1:0] readData,
    output csrIsaPkg::plvE               crmdPlv,
    output logic [csrUnitPkg::dataW-1:0] eraValue,
    output logic [csrUnitPkg::dataW-1:0] eentryValue
);

    logic [csrUnitPkg::dataW-1:0] crmd;
    logic [csrUnitPkg::dataW-1:0] prmd;
    logic [csrUnitPkg::dataW-1:0] estat;
    logic [csrUnitPkg::dataW-1:0] era;
    logic [csrUnitPkg::dataW-1:0] eentry;
    logic [csrUnitPkg::dataW-1:0] save [numSave];
    logic [numSave-1:0]           saveSel;
    logic [csrUnitPkg::dataW-1:0] rdValue;

    // only bits set in both masks take the new value
    function automatic logic [csrUnitPkg::dataW-1:0] merge(
        input logic [csrUnitPkg::dataW-1:0] old,
        input logic [csrUnitPkg::dataW-1:0] fieldMask
    );
        logic [csrUnitPkg::dataW-1:0] m;
        m = access.wmask & fieldMask;
        return (old & ~m) | (access.wdata & m);
    endfunction

    always_comb begin
        for (int i = 0; i < numSave; i++) begin
            saveSel[i] = (access.num == csrIsaPkg::csrSave0 + csrIsaPkg::csrNumW'(i));
        end
    end

    always_comb begin
        rdValue = '0;
        case (access.num)
            csrIsaPkg::csrCrmd:   rdValue = crmd;
            csrIsaPkg::csrPrmd:   rdValue = prmd;
            csrIsaPkg::csrEstat:  rdValue = estat;
            csrIsaPkg::csrEra:    rdValue = era;
            csrIsaPkg::csrEentry: rdValue = eentry;
            default: begin
                for (int i = 0; i < numSave; i++) begin
                    if (saveSel[i]) begin
                        rdValue = save[i];
                    end
                end
            end
        endcase
    end

    assign readData    = access.re ? rdValue : '0;
    assign crmdPlv     = csrIsaPkg::plvE'(crmd[1:0]);
    assign eraValue    = era;
    assign eentryValue = eentry;

    always_ff @(posedge Clk) begin
        if (reset) begin
            crmd   <= '0;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= csrIsaPkg::eentryReset;
            for (int i = 0; i < numSave; i++) begin
                save[i] <= '0;
            end
        end else if (access.excEnter) begin
            // exception entry drops to plv0 with interrupts off
            prmd[csrIsaPkg::plvIeW-1:0] <= crmd[csrIsaPkg::plvIeW-1:0];
            crmd[csrIsaPkg::plvIeW-1:0] <= '0;
            era <= access.excPc;
            estat[csrIsaPkg::ecodeLsb +: csrIsaPkg::ecodeW] <=
                access.excCode[csrIsaPkg::ecodeW-1:0];
        end else if (access.ertn) begin
            crmd[csrIsaPkg::plvIeW-1:0] <= prmd[csrIsaPkg::plvIeW-1:0];
        end else if (access.we) begin
            case (access.num)
                csrIsaPkg::csrCrmd:   crmd   <= merge(crmd, csrIsaPkg::crmdWrMask);
                csrIsaPkg::csrPrmd:   prmd   <= merge(prmd, csrIsaPkg::prmdWrMask);
                csrIsaPkg::csrEstat:  estat  <= merge(estat, csrIsaPkg::estatWrMask);
                csrIsaPkg::csrEra:    era    <= merge(era, csrIsaPkg::eraWrMask);
                csrIsaPkg::csrEentry: eentry <= merge(eentry, csrIsaPkg::eentryWrMask);
                default: begin
                    for (int i = 0; i < numSave; i++) begin
                        if (saveSel[i]) begin
                            save[i] <= merge(save[i], csrIsaPkg::saveWrMask);
                        end
                    end
                end
            endcase
        end
    end

    // the exec unit must never ask for two kinds of update at once
    assert property (@(posedge Clk) disable iff (reset)
        $onehot0({access.excEnter, access.ertn, access.we}));

endmodule

// ==== hw/csrExecUnit.sv ====
module csrExecUnit (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           issueValid,
    input  csrUnitPkg::csrIssueT           issue,
    output logic                           unitFree,
    output csrUnitPkg::robReportT          robReport,
    input  logic                           retireValid,
    input  logic [csrUnitPkg::robPtrW-1:0] retirePtr,
    input  logic                           stop,
    input  logic                           flush,
    output csrUnitPkg::wbT                 wb,
    output csrUnitPkg::csrAccessT          access,
    input  logic [csrUnitPkg::dataW-1:0]   readData,
    input  csrIsaPkg::plvE                 crmdPlv,
    input  logic [csrUnitPkg::dataW-1:0]   eraValue,
    input  logic [csrUnitPkg::dataW-1:0]   eentryValue
);

    typedef enum logic {
        unitIdle,
        unitBusy
    } unitStateE;

    unitStateE             state;
    csrUnitPkg::csrIssueT  held;
    logic                  fault;
    csrIsaPkg::excCodeE    faultCode;
    csrUnitPkg::robReportT nextReport;
    logic                  accept;
    logic                  retireHit;
    logic                  heldIsCsr;

    // RS is stalled by the same stop, so free is simply the idle state
    assign unitFree  = (state == unitIdle);
    assign accept    = issueValid && unitFree && !stop && !flush;
    assign retireHit = (state == unitBusy) && retireValid && (retirePtr == held.robPtr)
                       && !stop && !flush;
    assign heldIsCsr = held.op inside {csrIsaPkg::csrRd, csrIsaPkg::csrWr, csrIsaPkg::csrXchg};

    // redirect decode, privilege taken from CRMD at acceptance
    always_comb begin
        nextReport        = '0;
        nextReport.valid  = 1'b1;
        nextReport.robPtr = issue.robPtr;
        case (issue.op)
            csrIsaPkg::csrRd, csrIsaPkg::csrWr, csrIsaPkg::csrXchg: begin
                if (crmdPlv == csrIsaPkg::plv3) begin
                    nextReport.redirect    = 1'b1;
                    nextReport.isException = 1'b1;
                    nextReport.code        = csrIsaPkg::excPpi;
                    nextReport.target      = eentryValue;
                end
            end
            csrIsaPkg::opSyscall, csrIsaPkg::opBreak: begin
                nextReport.redirect    = 1'b1;
                nextReport.isException = 1'b1;
                nextReport.code        = (issue.op == csrIsaPkg::opSyscall) ?
                                         csrIsaPkg::excSys : csrIsaPkg::excBrk;
                nextReport.target      = eentryValue;
            end
            csrIsaPkg::opErtn: begin
                nextReport.redirect = 1'b1;
                if (crmdPlv == csrIsaPkg::plv3) begin
                    nextReport.isException = 1'b1;
                    nextReport.code        = csrIsaPkg::excPpi;
                    nextReport.target      = eentryValue;
                end else begin
                    nextReport.target = eraValue;
                end
            end
            csrIsaPkg::opIdle: nextReport.idle = 1'b1;
            default: ;
        endcase
    end

    // side effects only on the retiring edge
    always_comb begin
        access = '0;
        if (retireHit) begin
            if (fault) begin
                access.excEnter = 1'b1;
                access.excCode  = faultCode;
                access.excPc    = held.pc;
            end else if (heldIsCsr) begin
                access.re    = 1'b1;
                access.num   = held.csrNum;
                access.we    = (held.op != csrIsaPkg::csrRd);
                access.wdata = held.rdData;
                access.wmask = (held.op == csrIsaPkg::csrXchg) ? held.rjData : '1;
            end else if (held.op == csrIsaPkg::opErtn) begin
                access.ertn = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state           <= unitIdle;
            fault           <= 1'b0;
            robReport.valid <= 1'b0;
            wb.valid        <= 1'b0;
        end else if (!stop) begin
            robReport.valid <= 1'b0;
            wb.valid        <= retireHit && heldIsCsr && !fault;
            wb.addr         <= held.pdest;
            // old value, read before the write lands
            wb.data         <= readData;
            if (flush) begin
                state <= unitIdle;
            end else if (accept) begin
                state     <= unitBusy;
                held      <= issue;
                fault     <= nextReport.isException;
                faultCode <= nextReport.code;
                robReport <= nextReport;
            end else if (retireHit) begin
                state <= unitIdle;
            end
        end
    end

    // ROB must not retire the same entry twice
    assert property (@(posedge Clk) disable iff (reset)
        retireHit |=> !(retireValid && retirePtr == held.robPtr));

endmodule

// ==== hw/csrSubsystem.sv ====
module csrSubsystem #(
    parameter int numSave = 4
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           issueValid,
    input  csrUnitPkg::csrIssueT           issue,
    output logic                           unitFree,
    output csrUnitPkg::robReportT          robReport,
    input  logic                           retireValid,
    input  logic [csrUnitPkg::robPtrW-1:0] retirePtr,
    input  logic                           stop,
    input  logic                           flush,
    output csrUnitPkg::wbT                 wb,
    // current privilege for fetch and MMU
    output csrIsaPkg::plvE                 curPlv
);

    csrUnitPkg::csrAccessT        access;
    logic [csrUnitPkg::dataW-1:0] readData;
    logic [csrUnitPkg::dataW-1:0] eraValue;
    logic [csrUnitPkg::dataW-1:0] eentryValue;

    csrExecUnit execUnit_i (
        .Clk         (Clk),
        .reset       (reset),
        .issueValid  (issueValid),
        .issue       (issue),
        .unitFree    (unitFree),
        .robReport   (robReport),
        .retireValid (retireValid),
        .retirePtr   (retirePtr),
        .stop        (stop),
        .flush       (flush),
        .wb          (wb),
        .access      (access),
        .readData    (readData),
        .crmdPlv     (curPlv),
        .eraValue    (eraValue),
        .eentryValue (eentryValue)
    );

    csrRegFile #(
        .numSave (numSave)
    ) regFile_i (
        .Clk         (Clk),
        .reset       (reset),
        .access      (access),
        .readData    (readData),
        .crmdPlv     (curPlv),
        .eraValue    (eraValue),
        .eentryValue (eentryValue)
    );

endmodule

// ==== test/csrSubsystemTb.sv ====
module csrSubsystemTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numSave  = 4;
    localparam int numSteps = 24;
    localparam logic [31:0] eentryInit = 32'h1c00_0000;

    logic                           Clk;
    logic                           reset;
    logic                           issueValid;
    csrUnitPkg::csrIssueT           issue;
    logic                           unitFree;
    csrUnitPkg::robReportT          robReport;
    logic                           retireValid;
    logic [csrUnitPkg::robPtrW-1:0] retirePtr;
    logic                           stop;
    logic                           flush;
    csrUnitPkg::wbT                 wb;
    csrIsaPkg::plvE                 curPlv;

    // reference copy of the CSRs and of the held instruction
    logic [31:0]                    mCrmd;
    logic [31:0]                    mPrmd;
    logic [31:0]                    mEstat;
    logic [31:0]                    mEra;
    logic [31:0]                    mSave [numSave];
    logic                           modelBusy;
    csrUnitPkg::csrIssueT           heldPkt;
    logic                           heldExc;
    csrIsaPkg::excCodeE             heldCode;
    csrUnitPkg::robReportT          expRep;
    logic                           expWbValid;
    logic [csrUnitPkg::pregW-1:0]   expWbAddr;
    logic [31:0]                    expWbData;
    logic [csrUnitPkg::robPtrW-1:0] nextPtr;
    logic                           acceptNow;
    logic                           retireMatch;

    csrSubsystem #(.numSave(numSave)) dut_i (.*);

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    assign acceptNow   = issueValid && unitFree && !stop && !flush;
    assign retireMatch = retireValid && modelBusy && (retirePtr == heldPkt.robPtr)
                         && !stop && !flush;

    task automatic failValue(input string sig, input logic [31:0] expV, input logic [31:0] actV);
        $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, sig, expV, actV);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic failCheck(input string what);
        $display("%0t %s", $time, what);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] readCsr(input logic [13:0] num);
        logic [31:0] v;
        int          idx;
        idx = int'(num) - int'(csrIsaPkg::csrSave0);
        v = '0;
        case (num)
            csrIsaPkg::csrCrmd:   v = mCrmd;
            csrIsaPkg::csrPrmd:   v = mPrmd;
            csrIsaPkg::csrEstat:  v = mEstat;
            csrIsaPkg::csrEra:    v = mEra;
            csrIsaPkg::csrEentry: v = eentryInit;
            default: begin
                if (idx >= 0 && idx < numSave) begin
                    v = mSave[idx];
                end
            end
        endcase
        return v;
    endfunction

    // only plv and ie are writable in CRMD and PRMD
    function automatic void writeCsr(input logic [13:0] num, input logic [31:0] d,
                                     input logic [31:0] m);
        int idx;
        idx = int'(num) - int'(csrIsaPkg::csrSave0);
        if (num == csrIsaPkg::csrCrmd) begin
            mCrmd = (mCrmd & ~(m & 32'h7)) | (d & m & 32'h7);
        end else if (num == csrIsaPkg::csrPrmd) begin
            mPrmd = (mPrmd & ~(m & 32'h7)) | (d & m & 32'h7);
        end else if (idx >= 0 && idx < numSave) begin
            mSave[idx] = (mSave[idx] & ~m) | (d & m);
        end
    endfunction

    function automatic csrUnitPkg::robReportT expectReport(input csrUnitPkg::csrIssueT p);
        csrUnitPkg::robReportT r;
        r = '0;
        r.valid  = 1'b1;
        r.robPtr = p.robPtr;
        if (p.op == csrIsaPkg::opSyscall || p.op == csrIsaPkg::opBreak) begin
            r.redirect    = 1'b1;
            r.isException = 1'b1;
            r.code        = (p.op == csrIsaPkg::opSyscall) ?
                            csrIsaPkg::excSys : csrIsaPkg::excBrk;
            r.target      = eentryInit;
        end else if (p.op == csrIsaPkg::opIdle) begin
            r.idle = 1'b1;
        end else if (mCrmd[1:0] == 2'd3) begin
            // every remaining op is privileged
            r.redirect    = 1'b1;
            r.isException = 1'b1;
            r.code        = csrIsaPkg::excPpi;
            r.target      = eentryInit;
        end else if (p.op == csrIsaPkg::opErtn) begin
            r.redirect = 1'b1;
            r.target   = mEra;
        end
        return r;
    endfunction

    task automatic startIssue(input csrIsaPkg::csrOpE op, input logic [13:0] num,
                              input logic [31:0] data, input logic [31:0] mask);
        issue.op     = op;
        issue.csrNum = num;
        issue.robPtr = nextPtr;
        issue.pdest  = 7'($urandom_range(127, 1));
        issue.pc     = $urandom & 32'hffff_fffc;
        issue.rdData = data;
        issue.rjData = mask;
        nextPtr      = nextPtr + 1'b1;
        expRep       = expectReport(issue);
        issueValid   = 1'b1;
    endtask

    task automatic awaitAccept();
        while (!(unitFree && !stop && !flush)) begin
            @(negedge Clk);
        end
        @(negedge Clk);
        issueValid = 1'b0;
        heldPkt    = issue;
        heldExc    = expRep.isException;
        heldCode   = expRep.code;
        modelBusy  = 1'b1;
    endtask

    task automatic retireOp(input logic [csrUnitPkg::robPtrW-1:0] ptr);
        logic hit;
        hit         = modelBusy && (ptr == heldPkt.robPtr);
        retireValid = 1'b1;
        retirePtr   = ptr;
        if (hit) begin
            expWbValid = !heldExc &&
                heldPkt.op inside {csrIsaPkg::csrRd, csrIsaPkg::csrWr, csrIsaPkg::csrXchg};
            expWbAddr  = heldPkt.pdest;
            expWbData  = readCsr(heldPkt.csrNum);
        end
        @(negedge Clk);
        retireValid = 1'b0;
        if (hit) begin
            modelBusy = 1'b0;
            if (heldExc) begin
                mPrmd         = (mPrmd & ~32'h7) | (mCrmd & 32'h7);
                mCrmd         = mCrmd & ~32'h7;
                mEra          = heldPkt.pc;
                mEstat[21:16] = heldCode[5:0];
            end else if (expWbValid && heldPkt.op != csrIsaPkg::csrRd) begin
                writeCsr(heldPkt.csrNum, heldPkt.rdData,
                         (heldPkt.op == csrIsaPkg::csrXchg) ? heldPkt.rjData : 32'hffff_ffff);
            end else if (heldPkt.op == csrIsaPkg::opErtn) begin
                mCrmd = (mCrmd & ~32'h7) | (mPrmd & 32'h7);
            end
        end
    endtask

    task automatic runOp(input csrIsaPkg::csrOpE op, input logic [13:0] num,
                         input logic [31:0] data, input logic [31:0] mask);
        startIssue(op, num, data, mask);
        awaitAccept();
        @(negedge Clk);
        retireOp(heldPkt.robPtr);
    endtask

    assert property (@(posedge Clk) disable iff (reset) curPlv == mCrmd[1:0])
        else failValue("curPlv", mCrmd & 32'h3, 32'($sampled(curPlv)));
    assert property (@(posedge Clk) disable iff (reset) unitFree == !modelBusy)
        else failValue("unitFree", 32'(!modelBusy), 32'($sampled(unitFree)));
    assert property (@(posedge Clk) disable iff (reset) acceptNow |=> robReport.valid)
        else failCheck("no ROB report in the cycle after acceptance");
    assert property (@(posedge Clk) disable iff (reset) robReport.valid |-> $past(acceptNow))
        else failCheck("ROB report without an accepted issue");
    assert property (@(posedge Clk) disable iff (reset)
        robReport.valid |-> robReport.robPtr == expRep.robPtr)
        else failValue("robReport.robPtr", 32'(expRep.robPtr), 32'($sampled(robReport.robPtr)));
    assert property (@(posedge Clk) disable iff (reset) robReport.valid |->
        {robReport.redirect, robReport.isException, robReport.idle} ==
        {expRep.redirect, expRep.isException, expRep.idle})
        else failValue("robReport redirect/isException/idle",
            32'({expRep.redirect, expRep.isException, expRep.idle}),
            32'($sampled({robReport.redirect, robReport.isException, robReport.idle})));
    assert property (@(posedge Clk) disable iff (reset)
        robReport.valid && expRep.isException |-> robReport.code == expRep.code)
        else failValue("robReport.code", 32'(expRep.code), 32'($sampled(robReport.code)));
    assert property (@(posedge Clk) disable iff (reset)
        robReport.valid && expRep.redirect |-> robReport.target == expRep.target)
        else failValue("robReport.target", expRep.target, $sampled(robReport.target));
    assert property (@(posedge Clk) disable iff (reset) retireMatch |=> wb.valid == expWbValid)
        else failValue("wb.valid", 32'(expWbValid), 32'($sampled(wb.valid)));
    assert property (@(posedge Clk) disable iff (reset) wb.valid |-> $past(retireMatch))
        else failCheck("writeback without a matching retire");
    assert property (@(posedge Clk) disable iff (reset) wb.valid |-> wb.addr == expWbAddr)
        else failValue("wb.addr", 32'(expWbAddr), 32'($sampled(wb.addr)));
    assert property (@(posedge Clk) disable iff (reset) wb.valid |-> wb.data == expWbData)
        else failValue("wb.data", expWbData, $sampled(wb.data));
    assert property (@(posedge Clk) disable iff (reset) stop |=> $stable(unitFree))
        else failCheck("unitFree changed while stop was high");
    assert property (@(posedge Clk) disable iff (reset) flush && !stop |=> unitFree)
        else failCheck("unit not freed by flush");

    initial begin
        #((numSteps * 10 + 50) * 20);
        $display("timeout, the test sequence did not finish");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(93));
        {reset, issueValid, retireValid, stop, flush} = 5'b10000;
        issue      = '0;
        retirePtr  = '0;
        {mCrmd, mPrmd, mEstat, mEra} = '0;
        for (int i = 0; i < numSave; i++) begin
            mSave[i] = '0;
        end
        {modelBusy, heldExc, expWbValid} = '0;
        heldPkt    = '0;
        heldCode   = csrIsaPkg::excSys;
        expRep     = '0;
        expWbAddr  = '0;
        expWbData  = '0;
        nextPtr    = '0;
        repeat (3) @(negedge Clk);
        reset = 1'b0;
        @(negedge Clk);

        // write and read back in plv0, then masked exchange
        runOp(csrIsaPkg::csrWr, csrIsaPkg::csrSave0, $urandom, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrSave0, '0, '0);
        runOp(csrIsaPkg::csrXchg, csrIsaPkg::csrSave0, $urandom, $urandom);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrSave0, '0, '0);
        runOp(csrIsaPkg::csrWr, csrIsaPkg::csrSave0 + 14'd1, $urandom, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrSave0 + 14'd1, '0, '0);

        // privilege fault in plv3 enters the exception
        runOp(csrIsaPkg::csrWr, csrIsaPkg::csrCrmd, 32'h3, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrSave0, '0, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrPrmd, '0, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrEra, '0, '0);

        // syscall from plv3 and back with ertn
        runOp(csrIsaPkg::csrWr, csrIsaPkg::csrCrmd, 32'h3, '0);
        runOp(csrIsaPkg::opSyscall, '0, '0, '0);
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrEstat, '0, '0);
        runOp(csrIsaPkg::opErtn, '0, '0, '0);
        runOp(csrIsaPkg::opBreak, '0, '0, '0);
        runOp(csrIsaPkg::opIdle, '0, '0, '0);

        // second issue waits behind the busy unit
        startIssue(csrIsaPkg::csrWr, csrIsaPkg::csrSave0, $urandom, '0);
        awaitAccept();
        @(negedge Clk);
        startIssue(csrIsaPkg::csrRd, csrIsaPkg::csrSave0, '0, '0);
        repeat (3) @(negedge Clk);
        retireOp(heldPkt.robPtr + 6'd9);
        retireOp(heldPkt.robPtr);
        awaitAccept();
        @(negedge Clk);
        retireOp(heldPkt.robPtr);

        // stop holds a matching retire off, then flush drops the write
        startIssue(csrIsaPkg::csrWr, csrIsaPkg::csrSave0, $urandom, '0);
        awaitAccept();
        @(negedge Clk);
        stop        = 1'b1;
        retireValid = 1'b1;
        retirePtr   = heldPkt.robPtr;
        repeat (3) @(negedge Clk);
        stop        = 1'b0;
        retireValid = 1'b0;
        flush       = 1'b1;
        @(negedge Clk);
        flush       = 1'b0;
        modelBusy   = 1'b0;
        runOp(csrIsaPkg::csrRd, csrIsaPkg::csrSave0, '0, '0);

        repeat (2) @(negedge Clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== loongCsr.f ====
hw/csrIsaPkg.sv
hw/csrUnitPkg.sv
hw/csrRegFile.sv
hw/csrExecUnit.sv
hw/csrSubsystem.sv
test/csrSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run of the CSR subsystem testbench

VERILATOR ?= verilator
TOP       ?= csrSubsystemTb
FILELIST  ?= loongCsr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
